// ==== logic/arbiterPkg.sv ====
package arbiterPkg;

	// ------------------------------
	// Arbiter FSM
	// ------------------------------

	// One state per kind of outstanding work
	typedef enum logic [2:0] {
		stIdle        = 3'd0,
		stReadBg      = 3'd1,
		stReadClut    = 3'd2,
		stReadTexL    = 3'd3,
		stReadTexR    = 3'd4,
		stWriteBg     = 3'd5,
		stReadBgStart = 3'd6,
		stReadPair    = 3'd7
	} arbState_t;

	// ------------------------------
	// Queue entry opcodes
	// ------------------------------

	// Bit 0 set means a write to memory
	typedef enum logic [2:0] {
		opReadBlock  = 3'b000,
		opWriteBlock = 3'b001,
		opRead8      = 3'b010,
		opWritePixel = 3'b011,
		opReadPair   = 3'b110
	} queueOp_t;

	// Texture cache line address
	// Upper 15 bits pick the block, low 2 bits the 8-byte word
	typedef logic [16:0] texAdr_t;

	// Word slot inside the CLUT cache line
	typedef logic [2:0] clutIdx_t;

	// Two 16-bit pixels
	typedef logic [31:0] pixelData_t;

	// Memory command coming from the GPU pipeline
	typedef enum logic [2:0] {
		gpuNone        = 3'b000,
		gpuPixelToVram = 3'b001,
		gpuVramToCpu   = 3'b101
	} gpuCmd_t;

endpackage

// ==== logic/memBusPkg.sv ====
package memBusPkg;

	// ------------------------------
	// DDR bus side
	// ------------------------------

	// 1 MB of VRAM seen as 32768 blocks of 32 bytes
	typedef logic [14:0] blockAdr_t;

	// 4-byte slot inside a 32-byte block
	typedef logic [2:0] subAdr_t;

	// Full block, sixteen 16-bit pixels
	typedef logic [255:0] memData_t;

	// One enable bit per 16-bit halfword
	typedef logic [15:0] writeMask_t;

	// Access width on the bus
	typedef enum logic [1:0] {
		size8Byte  = 2'd0,
		size32Byte = 2'd1,
		size4Byte  = 2'd2
	} cmdSize_t;

endpackage

// ==== logic/requestDecoder.sv ====
`timescale 1ns/100ps

module requestDecoder
	import arbiterPkg::*;
	import memBusPkg::*;
(
	input  logic       i_gpuClk,
	input  logic       i_rstN,
	// GPU pipeline commands
	input  gpuCmd_t    i_gpuCmd,
	input  blockAdr_t  i_gpuAdr,
	input  subAdr_t    i_gpuSub,
	input  pixelData_t i_gpuPixels,
	input  logic [1:0] i_gpuPixMask,
	// Background block save and load
	input  logic [1:0] i_saveBgBlock,
	input  logic       i_isBlending,
	input  blockAdr_t  i_saveAdr,
	input  blockAdr_t  i_loadAdr,
	input  memData_t   i_exportedBg,
	input  writeMask_t i_exportedBgMask,
	// Cache clients
	input  logic       i_reqClut,
	input  blockAdr_t  i_clutAdr,
	input  logic       i_reqTexL,
	input  logic       i_reqTexR,
	input  texAdr_t    i_texAdrL,
	input  texAdr_t    i_texAdrR,
	// From queue and return path
	input  logic       i_queueFull,
	input  logic       i_readDone,
	// Queue entry
	output logic       o_push,
	output queueOp_t   o_op,
	output blockAdr_t  o_adr,
	output subAdr_t    o_subAdr,
	output memData_t   o_data,
	output writeMask_t o_mask,
	output arbState_t  o_state,
	output texAdr_t    o_texCacheAdr,
	output logic       o_resetMask
);

	arbState_t state;
	arbState_t nextState;
	logic      bgWorkQ;
	logic      bgPending;
	logic      bgClear;
	logic      latchTex;
	texAdr_t   texAdrQ;

	// Background request decode
	wire bgWork     = |i_saveBgBlock;
	wire bgStart    = bgWork && !bgWorkQ;
	wire firstBlend = (i_saveBgBlock == 2'b01) && i_isBlending;
	// Code 11 never blends
	wire blendBlock = i_isBlending && (i_saveBgBlock != 2'b11);

	// L side wins when both miss together
	wire texAdr_t texAdrSel = i_reqTexL ? i_texAdrL : i_texAdrR;

	// Pixel writes need no result so any state may take them
	wire pixTake = (i_gpuCmd == gpuPixelToVram) && !i_queueFull;

	// ------------------------------
	// Next state and queue entry
	// ------------------------------
	always_comb begin
		nextState = state;
		o_push    = 1'b0;
		o_op      = opReadBlock;
		o_adr     = '0;
		o_subAdr  = '0;
		o_data    = '0;
		o_mask    = '0;
		latchTex  = 1'b0;
		bgClear   = 1'b0;

		if (pixTake) begin
			o_push   = 1'b1;
			o_op     = opWritePixel;
			o_adr    = i_gpuAdr;
			o_subAdr = i_gpuSub;
			o_data   = {224'd0, i_gpuPixels};
			o_mask   = {14'd0, i_gpuPixMask};
		end

		case (state)
		stIdle: begin
			// Priority order is GPU, background, CLUT, texture L, texture R
			// Pair read is only taken here while the GPU holds it
			if (!pixTake && !i_queueFull) begin
				if (i_gpuCmd == gpuVramToCpu) begin
					o_push    = 1'b1;
					o_op      = opReadPair;
					o_adr     = i_gpuAdr;
					o_subAdr  = i_gpuSub;
					nextState = stReadPair;
				end else if (bgPending) begin
					bgClear = 1'b1;
					if (firstBlend) begin
						// First block when blending only loads
						o_push    = 1'b1;
						o_op      = opReadBlock;
						o_adr     = i_loadAdr;
						nextState = stReadBg;
					end else if (i_saveBgBlock[1]) begin
						o_push    = 1'b1;
						o_op      = opWriteBlock;
						o_adr     = i_saveAdr;
						o_data    = i_exportedBg;
						o_mask    = i_exportedBgMask;
						nextState = stWriteBg;
					end
				end else if (i_reqClut) begin
					o_push    = 1'b1;
					o_op      = opReadBlock;
					o_adr     = i_clutAdr;
					nextState = stReadClut;
				end else if (i_reqTexL || i_reqTexR) begin
					o_push    = 1'b1;
					o_op      = opRead8;
					o_adr     = texAdrSel[16:2];
					// 8-byte word to 4-byte slot
					o_subAdr  = {texAdrSel[1:0], 1'b0};
					latchTex  = 1'b1;
					nextState = i_reqTexL ? stReadTexL : stReadTexR;
				end
			end
		end
		stWriteBg: begin
			// Mask reset goes out in this single cycle
			nextState = blendBlock ? stReadBgStart : stIdle;
		end
		stReadBgStart: begin
			if (!pixTake && !i_queueFull) begin
				o_push    = 1'b1;
				o_op      = opReadBlock;
				o_adr     = i_loadAdr;
				nextState = stReadBg;
			end
		end
		default: begin
			// Read states wait for the return path
			if (i_readDone) begin
				nextState = stIdle;
			end
		end
		endcase
	end

	// ------------------------------
	// State and request registers
	// ------------------------------
	always_ff @(posedge i_gpuClk or negedge i_rstN) begin
		if (!i_rstN) begin
			state     <= stIdle;
			bgWorkQ   <= 1'b0;
			bgPending <= 1'b0;
		end else begin
			state   <= nextState;
			bgWorkQ <= bgWork;
			// Keep the edge until idle can serve it
			if (bgStart) begin
				bgPending <= 1'b1;
			end else if (bgClear) begin
				bgPending <= 1'b0;
			end
		end
	end

	// Cache line address for the write back
	always_ff @(posedge i_gpuClk) begin
		if (latchTex) begin
			texAdrQ <= texAdrSel;
		end
	end

	assign o_state       = state;
	assign o_texCacheAdr = texAdrQ;
	assign o_resetMask   = (state == stWriteBg);

	// Return path only finishes a read that is outstanding
	assert property (@(posedge i_gpuClk) disable iff (!i_rstN)
		i_readDone |-> (state inside {stReadBg, stReadClut, stReadTexL, stReadTexR, stReadPair}));

endmodule

// ==== logic/commandQueue.sv ====
`timescale 1ns/100ps

module commandQueue
	import arbiterPkg::*;
	import memBusPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic       i_gpuClk,
	input  logic       i_rstN,
	// Entry from the decoder
	input  logic       i_push,
	input  queueOp_t   i_op,
	input  blockAdr_t  i_adr,
	input  subAdr_t    i_subAdr,
	input  memData_t   i_data,
	input  writeMask_t i_mask,
	// DDR bus
	input  logic       i_busy,
	output logic       o_full,
	output logic       o_empty,
	output logic       o_command,
	output logic       o_write,
	output blockAdr_t  o_adr,
	output subAdr_t    o_subadr,
	output cmdSize_t   o_commandSize,
	output memData_t   o_dataOut,
	output writeMask_t o_writeMask
);

	localparam int PTR_W = $clog2(QUEUE_DEPTH);

	// Entry storage in one array per field
	queueOp_t   opMem   [QUEUE_DEPTH];
	blockAdr_t  adrMem  [QUEUE_DEPTH];
	subAdr_t    subMem  [QUEUE_DEPTH];
	memData_t   dataMem [QUEUE_DEPTH];
	writeMask_t maskMem [QUEUE_DEPTH];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [PTR_W:0]   count;
	queueOp_t         headOp;

	wire doPush = i_push && !o_full;
	// Head leaves in the cycle the bus is free
	wire doPop  = !o_empty && !i_busy;

	assign o_full  = (count == (PTR_W + 1)'(QUEUE_DEPTH));
	assign o_empty = (count == '0);

	always_ff @(posedge i_gpuClk) begin
		if (doPush) begin
			opMem[wrPtr]   <= i_op;
			adrMem[wrPtr]  <= i_adr;
			subMem[wrPtr]  <= i_subAdr;
			dataMem[wrPtr] <= i_data;
			maskMem[wrPtr] <= i_mask;
		end
	end

	// ------------------------------
	// Pointers and fill count
	// ------------------------------
	always_ff @(posedge i_gpuClk or negedge i_rstN) begin
		if (!i_rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap on their own with a power of two depth
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

	// ------------------------------
	// Head entry to bus command
	// ------------------------------
	assign headOp = opMem[rdPtr];

	always_comb begin
		case (headOp)
		opRead8:                  o_commandSize = size8Byte;
		opWritePixel, opReadPair: o_commandSize = size4Byte;
		default:                  o_commandSize = size32Byte;
		endcase
	end

	assign o_command   = doPop;
	assign o_write     = headOp[0];
	assign o_adr       = adrMem[rdPtr];
	// Whole block access starts at slot 0
	assign o_subadr    = (o_commandSize == size32Byte) ? '0 : subMem[rdPtr];
	assign o_dataOut   = dataMem[rdPtr];
	assign o_writeMask = maskMem[rdPtr];

	// Busy bus keeps the same head waiting
	assert property (@(posedge i_gpuClk) disable iff (!i_rstN)
		(!o_empty && i_busy) |=> (!o_empty && $stable(o_adr) && $stable(o_write)));

endmodule

// ==== logic/readReturn.sv ====
`timescale 1ns/100ps

module readReturn
	import arbiterPkg::*;
	import memBusPkg::*;
(
	input  logic       i_gpuClk,
	input  logic       i_rstN,
	input  arbState_t  i_state,
	input  memData_t   i_dataIn,
	input  logic       i_dataInValid,
	output logic       o_readDone,
	// Texture cache fill
	output logic       o_texWrite,
	output logic [63:0] o_texData,
	output logic       o_texCompleteL,
	output logic       o_texCompleteR,
	// CLUT cache fill
	output logic       o_clutWrite,
	output clutIdx_t   o_clutIndex,
	output pixelData_t o_clutData,
	output logic       o_clutComplete,
	// Background load
	output logic       o_importBg,
	output memData_t   o_importedBg,
	// Pixel pair to CPU
	output logic       o_readPairValid,
	output pixelData_t o_readPairValue
);

	memData_t dataQ;
	logic     validQ;
	clutIdx_t idx;

	wire isClut   = (i_state == stReadClut);
	wire isTexL   = (i_state == stReadTexL);
	wire isTexR   = (i_state == stReadTexR);
	wire lastWord = (idx == 3'd7);

	// Returned block, held for the CLUT walk
	always_ff @(posedge i_gpuClk) begin
		if (i_dataInValid) begin
			dataQ <= i_dataIn;
		end
	end

	// ------------------------------
	// Valid flag and CLUT index
	// ------------------------------
	always_ff @(posedge i_gpuClk or negedge i_rstN) begin
		if (!i_rstN) begin
			validQ <= 1'b0;
			idx    <= '0;
		end else begin
			// CLUT keeps valid up for all eight words
			validQ <= i_dataInValid || (validQ && isClut && !lastWord);
			if (validQ && isClut) begin
				idx <= idx + 1'b1;
			end else begin
				idx <= '0;
			end
		end
	end

	assign o_readDone = validQ && (!isClut || lastWord);

	assign o_texWrite     = validQ && (isTexL || isTexR);
	// 8-byte read lands in words 0 and 1
	assign o_texData      = dataQ[63:0];
	assign o_texCompleteL = validQ && isTexL;
	assign o_texCompleteR = validQ && isTexR;

	assign o_clutWrite    = validQ && isClut;
	assign o_clutIndex    = idx;
	assign o_clutData     = dataQ[{idx, 5'd0} +: 32];
	assign o_clutComplete = validQ && isClut && lastWord;

	assign o_importBg   = validQ && (i_state == stReadBg);
	assign o_importedBg = dataQ;

	assign o_readPairValid = validQ && (i_state == stReadPair);
	assign o_readPairValue = dataQ[31:0];

	// Decoder is back in idle right after delivery
	assert property (@(posedge i_gpuClk) disable iff (!i_rstN)
		o_readDone |=> (i_state == stIdle));

	// Bus data only while a read is outstanding
	assert property (@(posedge i_gpuClk) disable iff (!i_rstN)
		i_dataInValid |->
		(i_state inside {stReadBg, stReadClut, stReadTexL, stReadTexR, stReadPair}));

endmodule

// ==== logic/memoryArbiter.sv ====
`timescale 1ns/100ps

module memoryArbiter
	import arbiterPkg::*;
	import memBusPkg::*;
#(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic        i_gpuClk,
	input  logic        i_rstN,
	// GPU commands
	input  gpuCmd_t     i_gpuCmd,
	input  blockAdr_t   i_gpuAdr,
	input  subAdr_t     i_gpuSub,
	input  pixelData_t  i_gpuPixels,
	input  logic [1:0]  i_gpuPixMask,
	output logic        o_queueFull,
	output logic        o_queueEmpty,
	// Background blocks
	input  logic [1:0]  i_saveBgBlock,
	input  logic        i_isBlending,
	input  blockAdr_t   i_saveAdr,
	input  blockAdr_t   i_loadAdr,
	input  memData_t    i_exportedBg,
	input  writeMask_t  i_exportedBgMask,
	output logic        o_resetMask,
	output logic        o_importBg,
	output memData_t    o_importedBg,
	// CLUT cache
	input  logic        i_reqClut,
	input  blockAdr_t   i_clutAdr,
	output logic        o_clutWrite,
	output clutIdx_t    o_clutIndex,
	output pixelData_t  o_clutData,
	output logic        o_clutComplete,
	// Texture cache
	input  logic        i_reqTexL,
	input  logic        i_reqTexR,
	input  texAdr_t     i_texAdrL,
	input  texAdr_t     i_texAdrR,
	output logic        o_texWrite,
	output texAdr_t     o_texCacheAdr,
	output logic [63:0] o_texData,
	output logic        o_texCompleteL,
	output logic        o_texCompleteR,
	// Pair read
	output logic        o_readPairValid,
	output pixelData_t  o_readPairValue,
	// ------------------------------
	// DDR bus
	// ------------------------------
	input  logic        i_busy,
	output logic        o_command,
	output logic        o_write,
	output blockAdr_t   o_adr,
	output subAdr_t     o_subadr,
	output cmdSize_t    o_commandSize,
	output memData_t    o_dataOut,
	output writeMask_t  o_writeMask,
	input  memData_t    i_dataIn,
	input  logic        i_dataInValid
);

	// Decoder to queue
	logic       push;
	queueOp_t   op;
	blockAdr_t  adr;
	subAdr_t    subAdr;
	memData_t   data;
	writeMask_t mask;

	// Decoder and return path handshake
	arbState_t  state;
	logic       readDone;

	requestDecoder decoder (
		.i_gpuClk        (i_gpuClk),
		.i_rstN          (i_rstN),
		.i_gpuCmd        (i_gpuCmd),
		.i_gpuAdr        (i_gpuAdr),
		.i_gpuSub        (i_gpuSub),
		.i_gpuPixels     (i_gpuPixels),
		.i_gpuPixMask    (i_gpuPixMask),
		.i_saveBgBlock   (i_saveBgBlock),
		.i_isBlending    (i_isBlending),
		.i_saveAdr       (i_saveAdr),
		.i_loadAdr       (i_loadAdr),
		.i_exportedBg    (i_exportedBg),
		.i_exportedBgMask(i_exportedBgMask),
		.i_reqClut       (i_reqClut),
		.i_clutAdr       (i_clutAdr),
		.i_reqTexL       (i_reqTexL),
		.i_reqTexR       (i_reqTexR),
		.i_texAdrL       (i_texAdrL),
		.i_texAdrR       (i_texAdrR),
		.i_queueFull     (o_queueFull),
		.i_readDone      (readDone),
		.o_push          (push),
		.o_op            (op),
		.o_adr           (adr),
		.o_subAdr        (subAdr),
		.o_data          (data),
		.o_mask          (mask),
		.o_state         (state),
		.o_texCacheAdr   (o_texCacheAdr),
		.o_resetMask     (o_resetMask)
	);

	commandQueue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue (
		.i_gpuClk     (i_gpuClk),
		.i_rstN       (i_rstN),
		.i_push       (push),
		.i_op         (op),
		.i_adr        (adr),
		.i_subAdr     (subAdr),
		.i_data       (data),
		.i_mask       (mask),
		.i_busy       (i_busy),
		.o_full       (o_queueFull),
		.o_empty      (o_queueEmpty),
		.o_command    (o_command),
		.o_write      (o_write),
		.o_adr        (o_adr),
		.o_subadr     (o_subadr),
		.o_commandSize(o_commandSize),
		.o_dataOut    (o_dataOut),
		.o_writeMask  (o_writeMask)
	);

	readReturn returnPath (
		.i_gpuClk       (i_gpuClk),
		.i_rstN         (i_rstN),
		.i_state        (state),
		.i_dataIn       (i_dataIn),
		.i_dataInValid  (i_dataInValid),
		.o_readDone     (readDone),
		.o_texWrite     (o_texWrite),
		.o_texData      (o_texData),
		.o_texCompleteL (o_texCompleteL),
		.o_texCompleteR (o_texCompleteR),
		.o_clutWrite    (o_clutWrite),
		.o_clutIndex    (o_clutIndex),
		.o_clutData     (o_clutData),
		.o_clutComplete (o_clutComplete),
		.o_importBg     (o_importBg),
		.o_importedBg   (o_importedBg),
		.o_readPairValid(o_readPairValid),
		.o_readPairValue(o_readPairValue)
	);

endmodule

// ==== sim/ddrModel.sv ====
`timescale 1ns/100ps

module ddrModel
	import memBusPkg::*;
#(
	parameter logic [31:0] SEED = 32'h76b3690b
) (
	input  logic       i_gpuClk,
	input  logic       i_rstN,
	// Testbench holds the bus busy on top of the random busy
	input  logic       i_holdBusy,
	input  logic       i_command,
	input  logic       i_write,
	input  blockAdr_t  i_adr,
	input  subAdr_t    i_subadr,
	input  cmdSize_t   i_commandSize,
	input  memData_t   i_dataOut,
	input  writeMask_t i_writeMask,
	output logic       o_busy,
	output memData_t   o_dataIn,
	output logic       o_dataInValid
);

	logic [31:0] lfsr     = SEED;
	logic        randBusy = 1'b0;
	logic        validQ   = 1'b0;
	memData_t    dataQ    = '0;
	logic [2:0]  readPipe = '0;
	blockAdr_t   adrPipe [3];

	// Fibonacci LFSR, taps 32 22 2 1, new bit enters at bit 0
	function automatic logic [31:0] stepLfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Word k holds the block address over k
	function automatic memData_t blockPattern(input blockAdr_t adr);
		memData_t b;
		for (int k = 0; k < 8; k++) begin
			b[k*32 +: 32] = {1'b0, adr, 16'(k)};
		end
		return b;
	endfunction

	// ------------------------------
	// Read latency of three cycles
	// ------------------------------
	always @(posedge i_gpuClk or negedge i_rstN) begin
		if (!i_rstN) begin
			readPipe <= '0;
		end else begin
			readPipe <= {readPipe[1:0], i_command && !i_write};
		end
	end

	always @(posedge i_gpuClk) begin
		adrPipe[0] <= i_adr;
		adrPipe[1] <= adrPipe[0];
		adrPipe[2] <= adrPipe[1];
		// Write log
		if (i_command && i_write) begin
			$display("DDR write adr %h sub %0d size %s mask %h low word %h",
				i_adr, i_subadr, i_commandSize.name(), i_writeMask, i_dataOut[31:0]);
		end
	end

	// Bus side changes on the falling edge
	always @(negedge i_gpuClk) begin : driveBus
		logic [31:0] s1;
		logic [31:0] s2;
		s1 = stepLfsr(lfsr);
		s2 = stepLfsr(s1);
		lfsr     <= s2;
		// Two bits taken, busy about one cycle in four
		randBusy <= s1[0] & s2[0];
		validQ   <= readPipe[2];
		dataQ    <= blockPattern(adrPipe[2]);
	end

	assign o_busy        = i_holdBusy | randBusy;
	assign o_dataIn      = dataQ;
	assign o_dataInValid = validQ;

endmodule

// ==== sim/arbiterTb.sv ====
`timescale 1ns/100ps

module arbiterTb
	import arbiterPkg::*;
	import memBusPkg::*;
();

	localparam int TEST_COUNT  = 6;
	// Forty cycles per test
	localparam int CYCLE_LIMIT = 40 * TEST_COUNT;

	// First falling edge comes before the first rising edge
	logic        gpuClk = 1'b1;
	logic        rstN;
	gpuCmd_t     gpuCmd;
	blockAdr_t   gpuAdr;
	subAdr_t     gpuSub;
	pixelData_t  gpuPixels;
	logic [1:0]  gpuPixMask;
	logic [1:0]  saveBgBlock;
	logic        isBlending;
	blockAdr_t   saveAdr;
	blockAdr_t   loadAdr;
	memData_t    exportedBg;
	writeMask_t  exportedBgMask;
	logic        reqClut;
	blockAdr_t   clutAdr;
	logic        reqTexL;
	logic        reqTexR;
	texAdr_t     texAdrL;
	texAdr_t     texAdrR;
	logic        holdBusy;

	// DUT outputs
	logic        o_queueFull;
	logic        o_queueEmpty;
	logic        o_resetMask;
	logic        o_importBg;
	memData_t    o_importedBg;
	logic        o_clutWrite;
	clutIdx_t    o_clutIndex;
	pixelData_t  o_clutData;
	logic        o_clutComplete;
	logic        o_texWrite;
	texAdr_t     o_texCacheAdr;
	logic [63:0] o_texData;
	logic        o_texCompleteL;
	logic        o_texCompleteR;
	logic        o_readPairValid;
	pixelData_t  o_readPairValue;

	// DDR bus
	logic        busy;
	logic        o_command;
	logic        o_write;
	blockAdr_t   o_adr;
	subAdr_t     o_subadr;
	cmdSize_t    o_commandSize;
	memData_t    o_dataOut;
	writeMask_t  o_writeMask;
	memData_t    dataIn;
	logic        dataInValid;

	// ------------------------------
	// Expected values and counters
	// ------------------------------
	blockAdr_t   pixAdr  [8];
	subAdr_t     pixSub  [8];
	pixelData_t  pixData [8];
	logic [1:0]  pixMask [8];
	texAdr_t     texExpAdr [2];
	logic        texExpL   [2];
	int          pixCount     = 0;
	int          wrIdx        = 0;
	int          texIdx       = 0;
	int          clutCnt      = 0;
	int          bgWriteCnt   = 0;
	int          importCnt    = 0;
	int          resetMaskCnt = 0;
	int          pairCnt      = 0;
	int          cycles       = 0;
	int          errors       = 0;
	int          testsFailed  = 0;

	wire pixWrite = o_command && o_write && (o_commandSize == size4Byte);
	wire bgWrite  = o_command && o_write && (o_commandSize == size32Byte);

	always #10 gpuClk = ~gpuClk;

	memoryArbiter #(
		.QUEUE_DEPTH(4)
	) DUT (
		.i_gpuClk        (gpuClk),
		.i_rstN          (rstN),
		.i_gpuCmd        (gpuCmd),
		.i_gpuAdr        (gpuAdr),
		.i_gpuSub        (gpuSub),
		.i_gpuPixels     (gpuPixels),
		.i_gpuPixMask    (gpuPixMask),
		.o_queueFull     (o_queueFull),
		.o_queueEmpty    (o_queueEmpty),
		.i_saveBgBlock   (saveBgBlock),
		.i_isBlending    (isBlending),
		.i_saveAdr       (saveAdr),
		.i_loadAdr       (loadAdr),
		.i_exportedBg    (exportedBg),
		.i_exportedBgMask(exportedBgMask),
		.o_resetMask     (o_resetMask),
		.o_importBg      (o_importBg),
		.o_importedBg    (o_importedBg),
		.i_reqClut       (reqClut),
		.i_clutAdr       (clutAdr),
		.o_clutWrite     (o_clutWrite),
		.o_clutIndex     (o_clutIndex),
		.o_clutData      (o_clutData),
		.o_clutComplete  (o_clutComplete),
		.i_reqTexL       (reqTexL),
		.i_reqTexR       (reqTexR),
		.i_texAdrL       (texAdrL),
		.i_texAdrR       (texAdrR),
		.o_texWrite      (o_texWrite),
		.o_texCacheAdr   (o_texCacheAdr),
		.o_texData       (o_texData),
		.o_texCompleteL  (o_texCompleteL),
		.o_texCompleteR  (o_texCompleteR),
		.o_readPairValid (o_readPairValid),
		.o_readPairValue (o_readPairValue),
		.i_busy          (busy),
		.o_command       (o_command),
		.o_write         (o_write),
		.o_adr           (o_adr),
		.o_subadr        (o_subadr),
		.o_commandSize   (o_commandSize),
		.o_dataOut       (o_dataOut),
		.o_writeMask     (o_writeMask),
		.i_dataIn        (dataIn),
		.i_dataInValid   (dataInValid)
	);

	ddrModel memory (
		.i_gpuClk     (gpuClk),
		.i_rstN       (rstN),
		.i_holdBusy   (holdBusy),
		.i_command    (o_command),
		.i_write      (o_write),
		.i_adr        (o_adr),
		.i_subadr     (o_subadr),
		.i_commandSize(o_commandSize),
		.i_dataOut    (o_dataOut),
		.i_writeMask  (o_writeMask),
		.o_busy       (busy),
		.o_dataIn     (dataIn),
		.o_dataInValid(dataInValid)
	);

	task automatic reportMismatch(input string name, input logic [255:0] got,
		input logic [255:0] exp);
		errors++;
		$display("Fail %s: got %0h expected %0h at %0t", name, got, exp, $time);
	endtask

	task automatic reportProblem(input string msg);
		errors++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	// Memory content rule with the block address over the word number
	function automatic pixelData_t blockWord(input blockAdr_t adr, input int k);
		return {1'b0, adr, 16'(k)};
	endfunction

	function automatic memData_t fullBlock(input blockAdr_t adr);
		memData_t b;
		for (int k = 0; k < 8; k++) begin
			b[k*32 +: 32] = blockWord(adr, k);
		end
		return b;
	endfunction

	// Words 0 and 1 of the texture's block
	function automatic logic [63:0] texWords(input texAdr_t a);
		return {blockWord(a[16:2], 1), blockWord(a[16:2], 0)};
	endfunction

	// Holds the command until the queue has room
	task automatic sendPixel(input blockAdr_t adr, input subAdr_t sub,
		input pixelData_t pix, input logic [1:0] mask);
		logic full;
		pixAdr[pixCount]  = adr;
		pixSub[pixCount]  = sub;
		pixData[pixCount] = pix;
		pixMask[pixCount] = mask;
		pixCount++;
		gpuCmd     = gpuPixelToVram;
		gpuAdr     = adr;
		gpuSub     = sub;
		gpuPixels  = pix;
		gpuPixMask = mask;
		do begin
			full = o_queueFull;
			@(negedge gpuClk);
		end while (full);
		gpuCmd = gpuNone;
	endtask

	task automatic finishTest(input int num, input string name, input int mark);
		if (errors == mark) begin
			$display("Test %0d %s: passed", num, name);
		end else begin
			testsFailed++;
			$display("Test %0d %s: failed with %0d errors", num, name, errors - mark);
		end
	endtask

	always @(posedge gpuClk) begin
		cycles <= cycles + 1;
		if (pixWrite) begin
			wrIdx <= wrIdx + 1;
		end
		if (o_texWrite) begin
			texIdx <= texIdx + 1;
		end
		if (o_clutWrite) begin
			clutCnt <= clutCnt + 1;
		end
		if (bgWrite) begin
			bgWriteCnt <= bgWriteCnt + 1;
		end
		if (o_importBg) begin
			importCnt <= importCnt + 1;
		end
		if (o_resetMask) begin
			resetMaskCnt <= resetMaskCnt + 1;
		end
		if (o_readPairValid) begin
			pairCnt <= pairCnt + 1;
		end
	end

	// Run limit
	always @(posedge gpuClk) begin
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("=== FAIL ===");
			$finish;
		end
	end

	// ------------------------------
	// Pixel writes in push order
	// ------------------------------
	assert property (@(posedge gpuClk) disable iff (!rstN) pixWrite |-> wrIdx < pixCount)
		else reportProblem("Pixel write on the bus that was never sent");
	assert property (@(posedge gpuClk) disable iff (!rstN) pixWrite |-> o_adr == pixAdr[wrIdx])
		else reportMismatch("o_adr", $sampled(o_adr), pixAdr[$sampled(wrIdx)]);
	assert property (@(posedge gpuClk) disable iff (!rstN)
		pixWrite |-> o_subadr == pixSub[wrIdx])
		else reportMismatch("o_subadr", $sampled(o_subadr), pixSub[$sampled(wrIdx)]);
	assert property (@(posedge gpuClk) disable iff (!rstN)
		pixWrite |-> o_dataOut[31:0] == pixData[wrIdx])
		else reportMismatch("o_dataOut", $sampled(o_dataOut[31:0]), pixData[$sampled(wrIdx)]);
	assert property (@(posedge gpuClk) disable iff (!rstN)
		pixWrite |-> o_writeMask[1:0] == pixMask[wrIdx])
		else reportMismatch("o_writeMask", $sampled(o_writeMask), pixMask[$sampled(wrIdx)]);

	// Texture fill
	assert property (@(posedge gpuClk) disable iff (!rstN) o_texWrite |-> $past(dataInValid))
		else reportProblem("Texture write not one cycle after read data");
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_texWrite |-> o_texData == texWords(texExpAdr[texIdx]))
		else reportMismatch("o_texData", $sampled(o_texData),
			texWords(texExpAdr[$sampled(texIdx)]));
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_texWrite |-> o_texCacheAdr == texExpAdr[texIdx])
		else reportMismatch("o_texCacheAdr", $sampled(o_texCacheAdr),
			texExpAdr[$sampled(texIdx)]);
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_texWrite |-> o_texCompleteL == texExpL[texIdx] && o_texCompleteR != texExpL[texIdx])
		else reportProblem("Texture complete on the wrong side or missing");
	assert property (@(posedge gpuClk) disable iff (!rstN)
		(o_texCompleteL || o_texCompleteR) |-> o_texWrite)
		else reportProblem("Texture complete without a cache write");

	// CLUT walk over eight words
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_clutWrite |-> o_clutIndex == clutIdx_t'(clutCnt))
		else reportMismatch("o_clutIndex", $sampled(o_clutIndex), $sampled(clutCnt));
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_clutWrite |-> o_clutData == blockWord(clutAdr, clutCnt))
		else reportMismatch("o_clutData", $sampled(o_clutData),
			blockWord(clutAdr, $sampled(clutCnt)));
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_clutComplete |-> o_clutWrite && o_clutIndex == 3'd7)
		else reportProblem("CLUT complete not with the last word");

	// Background save and load
	assert property (@(posedge gpuClk) disable iff (!rstN) bgWrite |-> o_adr == saveAdr)
		else reportMismatch("o_adr", $sampled(o_adr), saveAdr);
	assert property (@(posedge gpuClk) disable iff (!rstN) bgWrite |-> o_subadr == '0)
		else reportMismatch("o_subadr", $sampled(o_subadr), 0);
	assert property (@(posedge gpuClk) disable iff (!rstN) bgWrite |-> o_dataOut == exportedBg)
		else reportMismatch("o_dataOut", $sampled(o_dataOut), exportedBg);
	assert property (@(posedge gpuClk) disable iff (!rstN)
		bgWrite |-> o_writeMask == exportedBgMask)
		else reportMismatch("o_writeMask", $sampled(o_writeMask), exportedBgMask);
	assert property (@(posedge gpuClk) disable iff (!rstN) o_resetMask |-> !$past(o_resetMask))
		else reportProblem("Mask reset held for more than one cycle");
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_importBg |-> o_importedBg == fullBlock(loadAdr))
		else reportMismatch("o_importedBg", $sampled(o_importedBg), fullBlock(loadAdr));

	// Pair read
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_readPairValid |-> $past(dataInValid))
		else reportProblem("Pair read result not one cycle after read data");
	assert property (@(posedge gpuClk) disable iff (!rstN)
		o_readPairValid |-> o_readPairValue == blockWord(gpuAdr, 0))
		else reportMismatch("o_readPairValue", $sampled(o_readPairValue), blockWord(gpuAdr, 0));

	initial begin
		int mark;
		gpuCmd         = gpuNone;
		gpuAdr         = '0;
		gpuSub         = '0;
		gpuPixels      = '0;
		gpuPixMask     = '0;
		saveBgBlock    = 2'b00;
		isBlending     = 1'b0;
		saveAdr        = '0;
		loadAdr        = '0;
		exportedBg     = '0;
		exportedBgMask = '0;
		reqClut        = 1'b0;
		clutAdr        = '0;
		reqTexL        = 1'b0;
		reqTexR        = 1'b0;
		texAdrL        = '0;
		texAdrR        = '0;
		holdBusy       = 1'b0;
		rstN           = 1'b1;

		// Reset over two rising edges
		@(negedge gpuClk);
		rstN = 1'b0;
		repeat (2) @(posedge gpuClk);
		@(negedge gpuClk);
		assert (!o_command && !o_queueFull && o_queueEmpty)
			else reportProblem("Queue flags not at their reset values");
		assert (!o_texWrite && !o_texCompleteL && !o_texCompleteR && !o_clutWrite &&
			!o_clutComplete && !o_resetMask && !o_importBg && !o_readPairValid)
			else reportProblem("Strobe high during reset");
		rstN = 1'b1;

		// Single pixel write
		mark = errors;
		sendPixel(15'h0123, 3'd5, 32'hcafe_babe, 2'b10);
		while (wrIdx < pixCount) @(negedge gpuClk);
		finishTest(1, "pixel write", mark);

		// Both sides miss together and L goes first
		mark         = errors;
		texExpAdr[0] = 17'h0a5b6;
		texExpL[0]   = 1'b1;
		texExpAdr[1] = 17'h13c2d;
		texExpL[1]   = 1'b0;
		texAdrL      = texExpAdr[0];
		texAdrR      = texExpAdr[1];
		reqTexL      = 1'b1;
		reqTexR      = 1'b1;
		while (reqTexL || reqTexR) begin
			@(negedge gpuClk);
			if (o_texCompleteL) begin
				reqTexL = 1'b0;
			end
			if (o_texCompleteR) begin
				reqTexR = 1'b0;
			end
		end
		@(negedge gpuClk);
		assert (texIdx == 2) else reportProblem("Expected two texture cache writes");
		finishTest(2, "texture L and R", mark);

		// CLUT load
		mark    = errors;
		clutAdr = 15'h2c3d;
		reqClut = 1'b1;
		while (reqClut) begin
			@(negedge gpuClk);
			if (o_clutComplete) begin
				reqClut = 1'b0;
			end
		end
		@(negedge gpuClk);
		assert (clutCnt == 8) else reportProblem("Expected eight CLUT words");
		finishTest(3, "CLUT load", mark);

		// Later block with blending
		mark           = errors;
		saveAdr        = 15'h1111;
		loadAdr        = 15'h2222;
		exportedBg     = {4{64'h0123_4567_89ab_cdef}};
		exportedBgMask = 16'hf0a5;
		isBlending     = 1'b1;
		saveBgBlock    = 2'b10;
		while (saveBgBlock != 2'b00) begin
			@(negedge gpuClk);
			if (o_importBg) begin
				saveBgBlock = 2'b00;
			end
		end
		isBlending = 1'b0;
		@(negedge gpuClk);
		assert (bgWriteCnt == 1 && importCnt == 1 && resetMaskCnt == 1)
			else reportProblem("Background write, mask reset or load missing");
		finishTest(4, "background blend", mark);

		// Bus held busy until the queue is full
		mark     = errors;
		holdBusy = 1'b1;
		for (int i = 0; i < 4; i++) begin
			sendPixel(15'h0200 + 15'(i), subAdr_t'(i), {16'h5a00 + 16'(i), 16'h0f00}, 2'(i));
		end
		assert (o_queueFull) else reportProblem("Queue not full with the bus held busy");
		fork
			sendPixel(15'h0204, 3'd4, 32'h5a04_0f00, 2'b11);
			begin
				repeat (3) @(negedge gpuClk);
				holdBusy = 1'b0;
			end
		join
		sendPixel(15'h0205, 3'd6, 32'h5a05_0f00, 2'b01);
		while (wrIdx < pixCount || !o_queueEmpty) @(negedge gpuClk);
		finishTest(5, "back-pressure", mark);

		// Pair read held until the value comes back
		mark   = errors;
		gpuAdr = 15'h3456;
		gpuSub = 3'd2;
		gpuCmd = gpuVramToCpu;
		while (gpuCmd != gpuNone) begin
			@(negedge gpuClk);
			if (o_readPairValid) begin
				gpuCmd = gpuNone;
			end
		end
		@(negedge gpuClk);
		assert (pairCnt == 1) else reportProblem("Expected one pair read result");
		finishTest(6, "pair read", mark);

		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			TEST_COUNT, TEST_COUNT - testsFailed, testsFailed, errors);
		if (errors == 0 && testsFailed == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== list.f ====
logic/arbiterPkg.sv
logic/memBusPkg.sv
logic/requestDecoder.sv
logic/commandQueue.sv
logic/readReturn.sv
logic/memoryArbiter.sv
sim/ddrModel.sv
sim/arbiterTb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module arbiterTb \
	-o arbiterSim || exit 1
./obj_dir/arbiterSim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || grep -q "=== PASS ===" sim.log || exit 1
